// File: include/pool_mif_defs.svh
`ifndef POOL_MIF_DEFS_SVH
`define POOL_MIF_DEFS_SVH

// Feature-map word width in bits
`define POOL_MIF_FM_W 32

// Activation buffer address width
`define POOL_MIF_ADDR_W 6

`endif

// File: hw/pool_mif_pkg.sv
`default_nettype none

`include "pool_mif_defs.svh"

package pool_mif_pkg;

    // ==================================================================
    // Subsystem sizes
    // ==================================================================
    localparam int POOL_CORE      = 4;
    localparam int POOL_COMP_CORE = 4;
    localparam int ACT_WIDTH      = 8;
    localparam int IDX_WIDTH      = `POOL_MIF_ADDR_W;
    localparam int GLB_DEPTH      = 1 << IDX_WIDTH;
    localparam int PORT_WIDTH     = 2;
    localparam int FM_WIDTH       = `POOL_MIF_FM_W;
    // Every FIFO is four entries deep
    localparam int FIFO_AW        = 2;
    // Command entry holds core number above the address
    localparam int CMD_WIDTH      = PORT_WIDTH + IDX_WIDTH;
    // Return entry holds core number above the word
    localparam int RET_WIDTH      = PORT_WIDTH + FM_WIDTH;

    // ==================================================================
    // Vector types
    // ==================================================================
    typedef logic [PORT_WIDTH-1:0]                port_idx_t;
    typedef logic [IDX_WIDTH-1:0]                 glb_addr_t;
    typedef logic [POOL_COMP_CORE*ACT_WIDTH-1:0]  fm_word_t;
    // Core 0 sits in the low bits
    typedef logic [POOL_CORE*IDX_WIDTH-1:0]       core_addr_bus_t;

endpackage

`default_nettype wire

// File: hw/fifo_fwft.sv
`timescale 1ns/100ps
`default_nettype none

// First-word-fall-through FIFO
// Head word shows on data_out while not empty
module fifo_fwft #(
    parameter int DATA_WIDTH = 8,
    parameter int ADDR_WIDTH = 2
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  push,
    input  wire logic                  pop,
    input  wire logic [DATA_WIDTH-1:0] data_in,
    output logic      [DATA_WIDTH-1:0] data_out,
    output logic                       empty,
    output logic                       full
);

    // Storage array
    logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

    logic [ADDR_WIDTH-1:0] wr_ptr;
    logic [ADDR_WIDTH-1:0] rd_ptr;
    // One extra bit so a full buffer is distinct from empty
    logic [ADDR_WIDTH:0]   count;

    logic do_push;
    logic do_pop;

    // Drop push on full and pop on empty
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    // ==================================================================
    // Flags and head word
    // ==================================================================
    assign empty    = (count == '0);
    // Count reaches depth only when the MSB is set
    assign full     = count[ADDR_WIDTH];
    assign data_out = mem[rd_ptr];

    // Write side
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    // ==================================================================
    // Pointers and occupancy
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap naturally at the power-of-two depth
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Push with pop leaves count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/prior_arb.sv
`timescale 1ns/100ps
`default_nettype none

// Fixed priority arbiter with core 0 highest
module prior_arb (
    input  wire logic [pool_mif_pkg::POOL_CORE-1:0] req,
    output logic      [pool_mif_pkg::POOL_CORE-1:0] gnt,
    output pool_mif_pkg::port_idx_t                 gnt_idx
);

    import pool_mif_pkg::*;

    // Isolate lowest set request bit
    // Zero when nobody asks
    assign gnt = req & (~req + 1'b1);

    // Encode winner number
    // Walk from top down so the lowest request writes last
    always_comb begin
        gnt_idx = '0;
        for (int i = POOL_CORE - 1; i >= 0; i--) begin
            if (req[i]) begin
                gnt_idx = port_idx_t'(i);
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/mif.sv
`timescale 1ns/100ps
`default_nettype none

// Memory interface between pooling cores and the activation buffer
module mif (
    input  wire logic                               clk,
    input  wire logic                               rst_n,

    // Core request channel
    input  wire logic [pool_mif_pkg::POOL_CORE-1:0] core_addr_vld,
    input  wire pool_mif_pkg::core_addr_bus_t       core_addr,
    output logic      [pool_mif_pkg::POOL_CORE-1:0] core_addr_rdy,

    // Buffer address channel
    output logic                                    glb_addr_vld,
    output pool_mif_pkg::glb_addr_t                 glb_addr,
    input  wire logic                               glb_addr_rdy,

    // Buffer data channel
    input  wire logic                               glb_fm_vld,
    input  wire pool_mif_pkg::fm_word_t             glb_fm,
    output logic                                    glb_fm_rdy,

    // Tagged return channel
    output logic                                    fm_vld,
    output pool_mif_pkg::fm_word_t                  fm_data,
    output pool_mif_pkg::port_idx_t                 fm_port,
    input  wire logic                               fm_rdy
);

    import pool_mif_pkg::*;

    logic [POOL_CORE-1:0] gnt;
    port_idx_t            gnt_idx;
    glb_addr_t            req_addr;
    logic                 req_xfer;
    logic                 cmd_empty;
    logic                 cmd_full;
    port_idx_t            cmd_port;
    logic                 addr_xfer;
    port_idx_t            tag_port;
    logic                 fm_in_xfer;
    logic                 out_empty;
    logic                 out_full;
    logic                 ret_xfer;

    // ==================================================================
    // Request arbitration
    // ==================================================================
    prior_arb u_prior_arb (
        .req     (core_addr_vld),
        .gnt     (gnt),
        .gnt_idx (gnt_idx)
    );

    // Only the winner sees ready, and only with room to queue
    assign core_addr_rdy = gnt & {POOL_CORE{~cmd_full}};
    assign req_xfer      = |(core_addr_vld & core_addr_rdy);
    // Slice the winner's address out of the packed bus
    assign req_addr      = core_addr[gnt_idx*IDX_WIDTH +: IDX_WIDTH];

    // ==================================================================
    // Command queue whose head drives the buffer address
    // ==================================================================
    fifo_fwft #(
        .DATA_WIDTH (CMD_WIDTH),
        .ADDR_WIDTH (FIFO_AW)
    ) u_cmd_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (req_xfer),
        .pop      (addr_xfer),
        .data_in  ({gnt_idx, req_addr}),
        .data_out ({cmd_port, glb_addr}),
        .empty    (cmd_empty),
        .full     (cmd_full)
    );

    assign glb_addr_vld = ~cmd_empty;
    assign addr_xfer    = glb_addr_vld & glb_addr_rdy;

    // Tags of reads inside the buffer pipeline
    // At most two reads in flight, so depth four never fills
    // and a word from the buffer always finds its tag
    fifo_fwft #(
        .DATA_WIDTH (PORT_WIDTH),
        .ADDR_WIDTH (FIFO_AW)
    ) u_tag_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (addr_xfer),
        .pop      (fm_in_xfer),
        .data_in  (cmd_port),
        .data_out (tag_port),
        .empty    (),
        .full     ()
    );

    // ==================================================================
    // Output queue of words tagged with their core
    // ==================================================================
    assign glb_fm_rdy = ~out_full;
    assign fm_in_xfer = glb_fm_vld & glb_fm_rdy;

    fifo_fwft #(
        .DATA_WIDTH (RET_WIDTH),
        .ADDR_WIDTH (FIFO_AW)
    ) u_out_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (fm_in_xfer),
        .pop      (ret_xfer),
        .data_in  ({tag_port, glb_fm}),
        .data_out ({fm_port, fm_data}),
        .empty    (out_empty),
        .full     (out_full)
    );

    assign fm_vld   = ~out_empty;
    assign ret_xfer = fm_vld & fm_rdy;

endmodule

`default_nettype wire

// File: hw/glb_bank.sv
`timescale 1ns/100ps
`default_nettype none

// Global activation buffer
// Plain write port and two-stage read pipeline with stall
module glb_bank (
    input  wire logic                   clk,
    input  wire logic                   rst_n,

    // Fill port, one word per high wr_en
    input  wire logic                   wr_en,
    input  wire pool_mif_pkg::glb_addr_t wr_addr,
    input  wire pool_mif_pkg::fm_word_t wr_data,

    // Read address channel
    input  wire logic                   addr_vld,
    input  wire pool_mif_pkg::glb_addr_t addr,
    output logic                        addr_rdy,

    // Read data channel
    output logic                        fm_vld,
    output pool_mif_pkg::fm_word_t      fm,
    input  wire logic                   fm_rdy
);

    import pool_mif_pkg::*;

    // Storage array
    fm_word_t  mem [GLB_DEPTH];

    logic      advance;
    // Stage one holds the captured address
    logic      s1_vld;
    glb_addr_t s1_addr;
    // Stage two holds the word read from the array
    logic      s2_vld;
    fm_word_t  s2_data;

    // ==================================================================
    // Stall control
    // ==================================================================
    // Move when output slot is free or being taken
    // Otherwise both stages hold
    assign advance  = ~s2_vld | fm_rdy;
    assign addr_rdy = advance;

    // Write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // ==================================================================
    // Pipeline valid bits
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_vld <= 1'b0;
            s2_vld <= 1'b0;
        end else if (advance) begin
            s1_vld <= addr_vld;
            s2_vld <= s1_vld;
        end
    end

    // Pipeline payload loads only with a valid entry
    always_ff @(posedge clk) begin
        if (advance && addr_vld) begin
            s1_addr <= addr;
        end
        if (advance && s1_vld) begin
            s2_data <= mem[s1_addr];
        end
    end

    // Output straight from stage two
    assign fm_vld = s2_vld;
    assign fm     = s2_data;

endmodule

`default_nettype wire

// File: hw/pool_mem_sys.sv
`timescale 1ns/100ps
`default_nettype none

// Pooling memory subsystem top
module pool_mem_sys (
    input  wire logic                               clk,
    input  wire logic                               rst_n,

    // Core requests
    input  wire logic [pool_mif_pkg::POOL_CORE-1:0] core_addr_vld,
    input  wire pool_mif_pkg::core_addr_bus_t       core_addr,
    output logic      [pool_mif_pkg::POOL_CORE-1:0] core_addr_rdy,

    // Shared return channel
    output logic                                    fm_vld,
    output pool_mif_pkg::fm_word_t                  fm_data,
    output pool_mif_pkg::port_idx_t                 fm_port,
    input  wire logic                               fm_rdy,

    // Buffer fill port
    input  wire logic                               wr_en,
    input  wire pool_mif_pkg::glb_addr_t            wr_addr,
    input  wire pool_mif_pkg::fm_word_t             wr_data
);

    import pool_mif_pkg::*;

    // ==================================================================
    // Links between mif and glb_bank
    // ==================================================================
    logic      glb_addr_vld;
    glb_addr_t glb_addr;
    logic      glb_addr_rdy;
    logic      glb_fm_vld;
    fm_word_t  glb_fm;
    logic      glb_fm_rdy;

    mif u_mif (
        .clk           (clk),
        .rst_n         (rst_n),
        .core_addr_vld (core_addr_vld),
        .core_addr     (core_addr),
        .core_addr_rdy (core_addr_rdy),
        .glb_addr_vld  (glb_addr_vld),
        .glb_addr      (glb_addr),
        .glb_addr_rdy  (glb_addr_rdy),
        .glb_fm_vld    (glb_fm_vld),
        .glb_fm        (glb_fm),
        .glb_fm_rdy    (glb_fm_rdy),
        .fm_vld        (fm_vld),
        .fm_data       (fm_data),
        .fm_port       (fm_port),
        .fm_rdy        (fm_rdy)
    );

    glb_bank u_glb_bank (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .addr_vld (glb_addr_vld),
        .addr     (glb_addr),
        .addr_rdy (glb_addr_rdy),
        .fm_vld   (glb_fm_vld),
        .fm       (glb_fm),
        .fm_rdy   (glb_fm_rdy)
    );

endmodule

`default_nettype wire

// File: verif/tb_pool_mem_sys.sv
`timescale 1ns/100ps
`default_nettype none

`include "pool_mif_defs.svh"

module tb_pool_mem_sys;

    import pool_mif_pkg::*;

    localparam string CASE_FILE   = "verif/mif_cases.txt";
    localparam int    HALF_PERIOD = 20;

    logic                 clk;
    logic                 rst_n;
    logic [POOL_CORE-1:0] core_addr_vld;
    core_addr_bus_t       core_addr;
    logic [POOL_CORE-1:0] core_addr_rdy;
    logic                 fm_vld;
    fm_word_t             fm_data;
    port_idx_t            fm_port;
    logic                 fm_rdy;
    logic                 wr_en;
    glb_addr_t            wr_addr;
    fm_word_t             wr_data;

    // Mirror of buffer contents
    logic [`POOL_MIF_FM_W-1:0] ref_mem [1 << `POOL_MIF_ADDR_W];
    // Expected returns in grant order
    string                     exp_name [$];
    port_idx_t                 exp_port [$];
    logic [`POOL_MIF_FM_W-1:0] exp_data [$];

    logic [31:0] lfsr_state  = 32'h4ec13d97;
    int          stall_pct   = 0;
    int          cycle_cnt   = 0;
    int          cycle_limit = 0;

    pool_mem_sys DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .core_addr_vld (core_addr_vld),
        .core_addr     (core_addr),
        .core_addr_rdy (core_addr_rdy),
        .fm_vld        (fm_vld),
        .fm_data       (fm_data),
        .fm_port       (fm_port),
        .fm_rdy        (fm_rdy),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data)
    );

    // ====================================================================
    // Helpers
    // ====================================================================
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit
    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = (val << 1) | lfsr_state[0];
        end
    endtask

    task automatic check_val(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
        if (actual !== expected) begin
            $display("error %s expected %0h actual %0h", name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "run aborted");
    endtask

    task automatic open_case_file(output int fd);
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            abort_run({"cannot open case file ", CASE_FILE});
        end
    endtask

    // Buffer writes only with no read in flight
    task automatic wait_drain();
        while (exp_name.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // Raise a request group where each core drops valid after its own transfer
    task automatic raise_requests(input string name, input logic [POOL_CORE-1:0] mask,
                                  input core_addr_bus_t addrs);
        logic [POOL_CORE-1:0] xfer;
        glb_addr_t            a;
        // Fixed priority grants the lowest core first
        for (int i = 0; i < POOL_CORE; i++) begin
            if (mask[i]) begin
                a = addrs[i*IDX_WIDTH +: IDX_WIDTH];
                exp_name.push_back(name);
                exp_port.push_back(port_idx_t'(i));
                exp_data.push_back(ref_mem[a]);
            end
        end
        core_addr     = addrs;
        core_addr_vld = mask;
        while (core_addr_vld != '0) begin
            // Sample ready mid-cycle
            #5;
            xfer = core_addr_vld & core_addr_rdy;
            @(negedge clk);
            core_addr_vld = core_addr_vld & ~xfer;
        end
    endtask

    // ====================================================================
    // Clock and watchdog
    // ====================================================================
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            abort_run($sformatf("timeout after %0d cycles with %0d returns pending",
                                cycle_cnt, exp_name.size()));
        end
    end

    // ====================================================================
    // Return channel with random fm_rdy and checking
    // ====================================================================
    initial begin : resp_check
        int r7;
        @(posedge rst_n);
        forever begin
            @(negedge clk);
            // Low with probability stall_pct out of 100
            take_bits(7, r7);
            fm_rdy = (r7 * 100 >= stall_pct * 128);
            #5;
            if (fm_vld && fm_rdy) begin
                if (exp_name.size() == 0) begin
                    abort_run($sformatf("return on port %0d with no read pending", fm_port));
                end else begin
                    check_val({exp_name[0], " port"}, exp_port[0], fm_port);
                    check_val({exp_name[0], " data"}, exp_data[0], fm_data);
                    void'(exp_name.pop_front());
                    void'(exp_port.pop_front());
                    void'(exp_data.pop_front());
                end
            end
        end
    end

    // ====================================================================
    // Case-file driver
    // ====================================================================
    initial begin : main_flow
        int                          fd;
        int                          rc;
        int                          n_lines;
        int                          pct;
        bit                          done;
        string                       kind;
        string                       name;
        string                       line;
        logic [3:0]                  mask;
        logic [`POOL_MIF_ADDR_W-1:0] a;
        logic [`POOL_MIF_ADDR_W-1:0] a0;
        logic [`POOL_MIF_ADDR_W-1:0] a1;
        logic [`POOL_MIF_ADDR_W-1:0] a2;
        logic [`POOL_MIF_ADDR_W-1:0] a3;
        logic [`POOL_MIF_FM_W-1:0]   d;
        rst_n         = 1'b0;
        core_addr_vld = '0;
        core_addr     = '0;
        fm_rdy        = 1'b0;
        wr_en         = 1'b0;
        wr_addr       = '0;
        wr_data       = '0;
        // Line count sets the cycle budget
        open_case_file(fd);
        n_lines = 0;
        while (!$feof(fd)) begin
            if ($fgets(line, fd) > 0) begin
                n_lines++;
            end
        end
        $fclose(fd);
        cycle_limit = n_lines * 40 + 200;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        #5;
        check_val("reset fm_vld", 0, fm_vld);
        check_val("reset core_addr_rdy", 0, core_addr_rdy);
        @(negedge clk);
        open_case_file(fd);
        done = 1'b0;
        while (!done) begin
            rc = $fscanf(fd, "%s", kind);
            if (rc != 1) begin
                abort_run("case file ended without an E line");
            end else if (kind == "#") begin
                rc = $fgets(line, fd);
            end else if (kind == "W") begin
                rc = $fscanf(fd, "%h %h", a, d);
                wait_drain();
                wr_en      = 1'b1;
                wr_addr    = a;
                wr_data    = d;
                ref_mem[a] = d;
                @(negedge clk);
                wr_en = 1'b0;
            end else if (kind == "P") begin
                rc = $fscanf(fd, "%d", pct);
                stall_pct = pct;
            end else if (kind == "R") begin
                rc = $fscanf(fd, "%s %h %h %h %h %h", name, mask, a0, a1, a2, a3);
                raise_requests(name, mask, {a3, a2, a1, a0});
            end else if (kind == "E") begin
                done = 1'b1;
            end else begin
                abort_run({"unknown case line kind ", kind});
            end
        end
        $fclose(fd);
        wait_drain();
        // A few idle cycles to catch stray returns
        repeat (4) @(negedge clk);
        if (!fm_vld) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("stray return word left on the channel after all reads");
            $display("=== FAIL ===");
            $fatal(1, "stray return");
        end
    end

endmodule

`default_nettype wire

// File: verif/mif_cases.txt
# W addr data | R name mask a0 a1 a2 a3 | P percent | E
# Hex fields except percent, mask bit i raises core i
P 0
W 00 11223344
W 05 a5a55a5a
W 1f deadbeef
W 2a 01020304
W 3f cafef00d
R single_c2 4 00 00 05 00
R all_cores f 1f 05 2a 3f
R pair_c1_c3 a 00 3f 00 1f
P 50
R bp_grp0 f 00 05 1f 2a
R bp_grp1 f 3f 2a 05 00
R bp_grp2 9 2a 00 00 05
R bp_grp3 6 00 1f 3f 00
W 05 0badf00d
W 2a 77665544
R rewrite f 05 2a 05 2a
P 80
R heavy_bp f 2a 3f 05 1f
R heavy_single 1 05 00 00 00
E

// File: flist.f
+incdir+include
hw/pool_mif_pkg.sv
hw/fifo_fwft.sv
hw/prior_arb.sv
hw/mif.sv
hw/glb_bank.sv
hw/pool_mem_sys.sv
verif/tb_pool_mem_sys.sv
